// ==== logic/rename_pkg.sv ====
package rename_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int RENAME_WIDTH  = 3;     // slots per group
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    localparam int AR_BITS = $clog2(NUM_ARCH_REGS);   // 5
    localparam int PR_BITS = $clog2(NUM_PHYS_REGS);   // 6

    // free list holds every tag not bound at reset
    localparam int FL_DEPTH    = NUM_PHYS_REGS - NUM_ARCH_REGS;
    localparam int FL_IDX_BITS = $clog2(FL_DEPTH);
    localparam int FL_CNT_BITS = FL_IDX_BITS + 1;     // count must reach FL_DEPTH

    //////////////////////////////
    // types
    //////////////////////////////
    typedef logic [AR_BITS-1:0] arch_reg_t;
    typedef logic [PR_BITS-1:0] phys_reg_t;

    // one incoming slot, 16 bits
    typedef struct packed {
        logic      valid;
        arch_reg_t dest_ar;
        arch_reg_t src1_ar;
        arch_reg_t src2_ar;
    } rename_req_t;

    // one renamed slot, 27 bits
    typedef struct packed {
        logic      valid;
        phys_reg_t dest_pr;      // 0 when nothing allocated
        phys_reg_t told_pr;      // previous mapping of dest
        phys_reg_t src1_pr;
        logic      src1_ready;
        phys_reg_t src2_pr;
        logic      src2_ready;
    } rename_rsp_t;

endpackage

// ==== logic/rename_ifs.sv ====
// lookup and update path between combiner and map table
interface map_lookup_if import rename_pkg::*; #(
    parameter int WIDTH = RENAME_WIDTH
) ();

    // request side, driven by the combiner
    arch_reg_t [WIDTH-1:0] src1_ar;
    arch_reg_t [WIDTH-1:0] src2_ar;
    arch_reg_t [WIDTH-1:0] dest_ar;
    logic      [WIDTH-1:0] alloc_en;     // only on the accepting cycle
    phys_reg_t [WIDTH-1:0] alloc_pr;     // new tag per slot

    // answers, combinational from the current table
    phys_reg_t [WIDTH-1:0] src1_pr;
    logic      [WIDTH-1:0] src1_ready;
    phys_reg_t [WIDTH-1:0] src2_pr;
    logic      [WIDTH-1:0] src2_ready;
    phys_reg_t [WIDTH-1:0] told_pr;

    modport renamer (
        output src1_ar, src2_ar, dest_ar, alloc_en, alloc_pr,
        input  src1_pr, src1_ready, src2_pr, src2_ready, told_pr
    );

    modport mapper (
        input  src1_ar, src2_ar, dest_ar, alloc_en, alloc_pr,
        output src1_pr, src1_ready, src2_pr, src2_ready, told_pr
    );

endinterface

// tag supply between combiner and free list
interface free_alloc_if import rename_pkg::*; #(
    parameter int WIDTH = RENAME_WIDTH
) ();

    localparam int POP_BITS = $clog2(WIDTH + 1);   // 0..WIDTH

    phys_reg_t [WIDTH-1:0]  head_pr;      // next WIDTH free tags, fifo order
    logic [FL_CNT_BITS-1:0] free_count;
    logic [POP_BITS-1:0]    pop_count;    // tags taken this cycle
    logic                   pop_en;       // high on accept

    modport renamer (
        input  head_pr, free_count,
        output pop_count, pop_en
    );

    modport pool (
        output head_pr, free_count,
        input  pop_count, pop_en
    );

endinterface

// ==== logic/map_table.sv ====
module map_table import rename_pkg::*; #(
    parameter int WIDTH = RENAME_WIDTH
) (
    input  logic                  clock,
    input  logic                  arst_n,
    map_lookup_if.mapper          lookup,
    input  logic      [WIDTH-1:0] cdb_valid,   // completion broadcast
    input  phys_reg_t [WIDTH-1:0] cdb_tag
);

    //////////////////////////////
    // state
    //////////////////////////////
    phys_reg_t                map_r [NUM_ARCH_REGS];   // speculative ar -> pr
    logic [NUM_PHYS_REGS-1:0] ready_r;                 // one bit per pr

    // is this tag on the cdb right now
    function automatic logic cdb_hit(input phys_reg_t pr);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < WIDTH; k++) begin
            if (cdb_valid[k] && (cdb_tag[k] == pr)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //////////////////////////////
    // lookup
    //////////////////////////////
    always_comb begin
        phys_reg_t s1_pr;
        phys_reg_t s2_pr;
        for (int i = 0; i < WIDTH; i++) begin
            s1_pr = map_r[lookup.src1_ar[i]];
            s2_pr = map_r[lookup.src2_ar[i]];

            lookup.src1_pr[i]    = s1_pr;
            lookup.src1_ready[i] = ready_r[s1_pr] | cdb_hit(s1_pr);   // same-cycle bypass
            lookup.src2_pr[i]    = s2_pr;
            lookup.src2_ready[i] = ready_r[s2_pr] | cdb_hit(s2_pr);

            // old mapping, freed when this inst retires
            lookup.told_pr[i] = map_r[lookup.dest_ar[i]];
        end
    end

    //////////////////////////////
    // update
    //////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int a = 0; a < NUM_ARCH_REGS; a++) begin
                map_r[a] <= phys_reg_t'(a);    // identity
            end
            ready_r <= '1;                     // all values committed
        end else begin
            // completions first
            for (int k = 0; k < WIDTH; k++) begin
                if (cdb_valid[k]) begin
                    ready_r[cdb_tag[k]] <= 1'b1;
                end
            end

            // new mappings in slot order, later slot overrides
            for (int i = 0; i < WIDTH; i++) begin
                if (lookup.alloc_en[i] && (lookup.dest_ar[i] != '0)) begin  // x0 stays on pr 0
                    map_r[lookup.dest_ar[i]]    <= lookup.alloc_pr[i];
                    ready_r[lookup.alloc_pr[i]] <= 1'b0;                    // value pending
                end
            end
        end
    end

endmodule

// ==== logic/free_list.sv ====
module free_list import rename_pkg::*; #(
    parameter int WIDTH = RENAME_WIDTH
) (
    input  logic                  clock,
    input  logic                  arst_n,
    free_alloc_if.pool            alloc,
    input  logic      [WIDTH-1:0] retire_valid,
    input  phys_reg_t [WIDTH-1:0] retire_told    // tags handed back
);

    localparam int POP_BITS = $clog2(WIDTH + 1);

    //////////////////////////////
    // storage and pointers
    //////////////////////////////
    phys_reg_t              fifo_r [FL_DEPTH];
    logic [FL_IDX_BITS-1:0] head_r;        // oldest free tag
    logic [FL_IDX_BITS-1:0] tail_r;        // next write slot
    logic [FL_CNT_BITS-1:0] count_r;

    logic [WIDTH-1:0]       push_en;
    logic [FL_IDX_BITS-1:0] push_idx [WIDTH];
    logic [POP_BITS-1:0]    push_num;
    logic [POP_BITS-1:0]    pop_num;

    //////////////////////////////
    // read side
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            alloc.head_pr[i] = fifo_r[head_r + FL_IDX_BITS'(i)];   // wraps on depth
        end
    end

    assign alloc.free_count = count_r;
    assign pop_num          = alloc.pop_en ? alloc.pop_count : '0;

    //////////////////////////////
    // return side
    //////////////////////////////
    // pack valid returns behind tail in slot order
    always_comb begin
        push_num = '0;
        for (int i = 0; i < WIDTH; i++) begin
            push_en[i]  = retire_valid[i] && (retire_told[i] != '0);   // pr 0 belongs to x0
            push_idx[i] = tail_r + FL_IDX_BITS'(push_num);
            if (push_en[i]) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < FL_DEPTH; k++) begin
                fifo_r[k] <= phys_reg_t'(NUM_ARCH_REGS + k);   // tags 32..63
            end
            head_r  <= '0;
            tail_r  <= '0;                                     // full, tail meets head
            count_r <= FL_CNT_BITS'(FL_DEPTH);
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (push_en[i]) begin
                    fifo_r[push_idx[i]] <= retire_told[i];
                end
            end
            head_r  <= head_r + FL_IDX_BITS'(pop_num);
            tail_r  <= tail_r + FL_IDX_BITS'(push_num);
            count_r <= count_r - FL_CNT_BITS'(pop_num) + FL_CNT_BITS'(push_num);
        end
    end

endmodule

// ==== logic/rename_combiner.sv ====
module rename_combiner import rename_pkg::*; #(
    parameter int WIDTH = RENAME_WIDTH
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  rename_req_t [WIDTH-1:0] in_req,
    output logic                    in_ready,
    output logic                    out_valid,
    output rename_rsp_t [WIDTH-1:0] out_rsp,
    input  logic                    out_ready,
    map_lookup_if.renamer           lookup,
    free_alloc_if.renamer           alloc
);

    localparam int POP_BITS = $clog2(WIDTH + 1);

    logic [WIDTH-1:0]        need;          // valid slot with nonzero dest
    phys_reg_t [WIDTH-1:0]   new_pr;        // tag offered to each slot
    logic [POP_BITS-1:0]     need_count;
    logic                    accept;
    logic                    live_r;        // free list seen full since reset
    logic                    out_valid_r;
    rename_rsp_t [WIDTH-1:0] rsp_next;
    rename_rsp_t [WIDTH-1:0] out_rsp_r;

    //////////////////////////////
    // tag assignment
    //////////////////////////////
    // consecutive head tags go to the slots that need one
    always_comb begin
        need_count = '0;
        for (int i = 0; i < WIDTH; i++) begin
            need[i]   = in_req[i].valid && (in_req[i].dest_ar != '0);
            new_pr[i] = alloc.head_pr[need_count];   // never past slot i
            if (need[i]) begin
                need_count = need_count + 1'b1;
            end
        end
    end

    //////////////////////////////
    // handshake
    //////////////////////////////
    assign in_ready = live_r
                   && (!out_valid_r || out_ready)                            // room downstream
                   && (alloc.free_count >= FL_CNT_BITS'(need_count));        // enough tags
    assign accept   = in_valid && in_ready;

    assign alloc.pop_en    = accept;
    assign alloc.pop_count = need_count;

    // table lookup, writes gated by accept
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            lookup.src1_ar[i]  = in_req[i].src1_ar;
            lookup.src2_ar[i]  = in_req[i].src2_ar;
            lookup.dest_ar[i]  = in_req[i].dest_ar;
            lookup.alloc_en[i] = accept && need[i];
            lookup.alloc_pr[i] = new_pr[i];
        end
    end

    //////////////////////////////
    // intra-group fixup
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            rsp_next[i].valid      = in_req[i].valid;
            rsp_next[i].dest_pr    = need[i] ? new_pr[i] : '0;
            rsp_next[i].told_pr    = lookup.told_pr[i];
            rsp_next[i].src1_pr    = lookup.src1_pr[i];
            rsp_next[i].src1_ready = lookup.src1_ready[i];
            rsp_next[i].src2_pr    = lookup.src2_pr[i];
            rsp_next[i].src2_ready = lookup.src2_ready[i];

            // walk older slots upward, newest producer wins
            for (int j = 0; j < i; j++) begin
                if (need[j]) begin
                    if (in_req[i].src1_ar == in_req[j].dest_ar) begin
                        rsp_next[i].src1_pr    = new_pr[j];
                        rsp_next[i].src1_ready = 1'b0;     // producer not done yet
                    end
                    if (in_req[i].src2_ar == in_req[j].dest_ar) begin
                        rsp_next[i].src2_pr    = new_pr[j];
                        rsp_next[i].src2_ready = 1'b0;
                    end
                    if (in_req[i].dest_ar == in_req[j].dest_ar) begin
                        rsp_next[i].told_pr = new_pr[j];   // waw inside group
                    end
                end
            end

            if (!in_req[i].valid) begin
                rsp_next[i] = '0;                          // empty slot
            end
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            live_r      <= 1'b0;
            out_valid_r <= 1'b0;
        end else begin
            if (alloc.free_count == FL_CNT_BITS'(FL_DEPTH)) begin
                live_r <= 1'b1;
            end
            if (accept) begin
                out_valid_r <= 1'b1;
            end else if (out_ready) begin
                out_valid_r <= 1'b0;                       // drained
            end
        end
    end

    // payload only, held while stalled
    always_ff @(posedge clock) begin
        if (accept) begin
            out_rsp_r <= rsp_next;
        end
    end

    assign out_valid = out_valid_r;
    assign out_rsp   = out_rsp_r;

endmodule

// ==== logic/rename_unit.sv ====
module rename_unit import rename_pkg::*; #(
    parameter int WIDTH = RENAME_WIDTH
) (
    input  logic                    clock,
    input  logic                    arst_n,

    // incoming group
    input  logic                    in_valid,
    input  rename_req_t [WIDTH-1:0] in_req,
    output logic                    in_ready,

    // renamed group
    output logic                    out_valid,
    output rename_rsp_t [WIDTH-1:0] out_rsp,
    input  logic                    out_ready,

    // completion broadcast
    input  logic        [WIDTH-1:0] cdb_valid,
    input  phys_reg_t   [WIDTH-1:0] cdb_tag,

    // retirement, told tags back to the pool
    input  logic        [WIDTH-1:0] retire_valid,
    input  phys_reg_t   [WIDTH-1:0] retire_told
);

    //////////////////////////////
    // internal buses
    //////////////////////////////
    map_lookup_if #(.WIDTH(WIDTH)) lookup_bus ();
    free_alloc_if #(.WIDTH(WIDTH)) alloc_bus ();

    //////////////////////////////
    // map table and free list
    //////////////////////////////
    map_table #(
        .WIDTH (WIDTH)
    ) u_map_table (
        .clock     (clock),
        .arst_n    (arst_n),
        .lookup    (lookup_bus.mapper),    // lookups and new mappings
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag)               // sets ready bits
    );

    free_list #(
        .WIDTH (WIDTH)
    ) u_free_list (
        .clock        (clock),
        .arst_n       (arst_n),
        .alloc        (alloc_bus.pool),    // head tags and pops
        .retire_valid (retire_valid),
        .retire_told  (retire_told)
    );

    //////////////////////////////
    // combiner
    //////////////////////////////
    // merges both answers, owns handshake and output reg
    rename_combiner #(
        .WIDTH (WIDTH)
    ) u_rename_combiner (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_rsp   (out_rsp),
        .out_ready (out_ready),
        .lookup    (lookup_bus.renamer),
        .alloc     (alloc_bus.renamer)
    );

endmodule

// ==== test/rename_checker.sv ====
module rename_checker import rename_pkg::*; (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic                           in_valid,
    input  rename_req_t [RENAME_WIDTH-1:0] in_req,
    input  logic                           in_ready,
    input  logic                           out_valid,
    input  rename_rsp_t [RENAME_WIDTH-1:0] out_rsp,
    input  logic                           out_ready,
    input  logic        [RENAME_WIDTH-1:0] cdb_valid,
    input  phys_reg_t   [RENAME_WIDTH-1:0] cdb_tag,
    input  logic        [RENAME_WIDTH-1:0] retire_valid,
    input  phys_reg_t   [RENAME_WIDTH-1:0] retire_told,
    input  logic        [8*16-1:0]         test_name,
    input  phys_reg_t   [RENAME_WIDTH-1:0] exp_dest,   // table values for this row
    output int                             error_count,
    output int                             pending
);
    timeunit 1ns;
    timeprecision 100ps;

    phys_reg_t                        map_m [NUM_ARCH_REGS];
    logic [NUM_PHYS_REGS-1:0]         ready_m;
    phys_reg_t                        free_q [$];
    rename_rsp_t [RENAME_WIDTH-1:0]   exp_q [$];
    phys_reg_t [RENAME_WIDTH-1:0]     dest_q [$];
    logic [8*16-1:0]                  name_q [$];
    rename_rsp_t [RENAME_WIDTH-1:0]   held_rsp;
    logic                             held;
    logic                             live_m;      // first cycle after reset is dead
    logic                             exp_ready;

    function automatic logic on_cdb(input phys_reg_t pr);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            hit |= cdb_valid[k] && (cdb_tag[k] == pr);
        end
        return hit;
    endfunction

    // slots that take a tag from the pool
    function automatic int tags_needed(input rename_req_t [RENAME_WIDTH-1:0] req);
        int n;
        n = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (req[i].valid && (req[i].dest_ar != '0)) begin
                n++;
            end
        end
        return n;
    endfunction

    // rename slot by slot against a working copy of the map
    task automatic predict_group();
        phys_reg_t                      work [NUM_ARCH_REGS];
        logic [NUM_PHYS_REGS-1:0]       fresh;
        rename_rsp_t [RENAME_WIDTH-1:0] e;
        work  = map_m;
        fresh = '0;
        e     = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (in_req[i].valid) begin
                e[i].valid      = 1'b1;
                e[i].src1_pr    = work[in_req[i].src1_ar];
                e[i].src1_ready = !fresh[e[i].src1_pr] && (ready_m[e[i].src1_pr] ||
                                  on_cdb(e[i].src1_pr));
                e[i].src2_pr    = work[in_req[i].src2_ar];
                e[i].src2_ready = !fresh[e[i].src2_pr] && (ready_m[e[i].src2_pr] ||
                                  on_cdb(e[i].src2_pr));
                e[i].told_pr    = work[in_req[i].dest_ar];
                if (in_req[i].dest_ar != '0) begin
                    if (free_q.size() == 0) begin
                        error_count++;
                        $display("%0s accepted with no free tag left", test_name);
                    end else begin
                        e[i].dest_pr = free_q.pop_front();
                        work[in_req[i].dest_ar] = e[i].dest_pr;
                        fresh[e[i].dest_pr] = 1'b1;
                    end
                end
            end
        end
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            if (cdb_valid[k]) ready_m[cdb_tag[k]] = 1'b1;
        end
        ready_m &= ~fresh;                      // new tags pending
        map_m = work;
        exp_q.push_back(e);
        dest_q.push_back(exp_dest);
        name_q.push_back(test_name);
    endtask

    task automatic check_output();
        rename_rsp_t [RENAME_WIDTH-1:0] e;
        phys_reg_t [RENAME_WIDTH-1:0]   d;
        logic [8*16-1:0]                nm;
        if (exp_q.size() == 0) begin
            error_count++;
            $display("output handshake with no group outstanding");
            return;
        end
        e  = exp_q.pop_front();
        d  = dest_q.pop_front();
        nm = name_q.pop_front();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (out_rsp[i] !== e[i] || out_rsp[i].dest_pr !== d[i]) begin
                error_count++;
                $display("[ERROR] %0s slot %0d: expected %h (dest %0d) actual %h", nm, i,
                         e[i], d[i], out_rsp[i]);
            end
        end
    endtask

    initial error_count = 0;

    // negedge sampling, inputs and outputs both settled
    always @(negedge clock) begin
        if (!arst_n) begin
            for (int a = 0; a < NUM_ARCH_REGS; a++) map_m[a] = phys_reg_t'(a);
            ready_m = '1;
            free_q.delete();
            for (int k = NUM_ARCH_REGS; k < NUM_PHYS_REGS; k++) free_q.push_back(phys_reg_t'(k));
            exp_q.delete();
            dest_q.delete();
            name_q.delete();
            held   = 1'b0;
            live_m = 1'b0;
        end else begin
            if (held && (out_rsp !== held_rsp || !out_valid)) begin
                error_count++;
                $display("output changed while stalled");
            end
            held     = out_valid && !out_ready;
            held_rsp = out_rsp;

            // room downstream and enough tags for this group
            exp_ready = live_m && (!out_valid || out_ready)
                     && (free_q.size() >= tags_needed(in_req));
            if (in_ready !== exp_ready) begin
                error_count++;
                $display("[ERROR] %0s in_ready: expected %b actual %b", test_name, exp_ready,
                         in_ready);
            end

            if (out_valid && out_ready) check_output();
            if (in_valid && in_ready) begin
                predict_group();
            end else begin
                for (int k = 0; k < RENAME_WIDTH; k++) begin
                    if (cdb_valid[k]) ready_m[cdb_tag[k]] = 1'b1;
                end
            end
            for (int k = 0; k < RENAME_WIDTH; k++) begin   // returns in slot order
                if (retire_valid[k] && retire_told[k] != '0) free_q.push_back(retire_told[k]);
            end
            live_m = 1'b1;                                 // pool full at the first edge
        end
        pending = exp_q.size();
    end

endmodule

// ==== test/tb_rename.sv ====
module tb_rename import rename_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 15;
    localparam int TIMEOUT  = 200;   // cycles per wait
    localparam int STALL    = 3;     // cycles held off before retiring

    typedef logic [8*16-1:0] name_t;
    typedef struct {
        name_t              name;
        rename_req_t [2:0]  req;
        logic [2:0]         cv;
        phys_reg_t [2:0]    ct;
        logic [2:0]         rv;
        phys_reg_t [2:0]    rt;
        logic               stall;
        phys_reg_t [2:0]    dest;   // expected new tags
    } row_t;

    logic clock, arst_n, in_valid, in_ready, out_valid, out_ready;
    rename_req_t [2:0] in_req;
    rename_rsp_t [2:0] out_rsp;
    logic [2:0] cdb_valid, retire_valid;
    phys_reg_t [2:0] cdb_tag, retire_told, cur_dest;
    name_t cur_name;
    row_t table_r [NUM_ROWS];
    int tb_errors, chk_errors, pending, seed;

    rename_unit #(.WIDTH(RENAME_WIDTH)) uut (.*);

    rename_checker u_checker (.*, .test_name(cur_name), .exp_dest(cur_dest),
                              .error_count(chk_errors), .pending(pending));

    function automatic rename_req_t slot(input logic v, input int d, input int s1, input int s2);
        return '{valid: v, dest_ar: arch_reg_t'(d), src1_ar: arch_reg_t'(s1),
                 src2_ar: arch_reg_t'(s2)};
    endfunction

    task automatic add_row(input int n, input name_t nm, input rename_req_t a, b, c,
                           input logic [2:0] cv, input phys_reg_t [2:0] ct,
                           input logic [2:0] rv, input phys_reg_t [2:0] rt,
                           input logic st, input phys_reg_t [2:0] dest);
        table_r[n] = '{nm, {c, b, a}, cv, ct, rv, rt, st, dest};
    endtask

    task automatic build_table();
        add_row(0, "basic", slot(1, 1, 2, 3), slot(1, 4, 5, 6), slot(1, 7, 8, 9),
                0, 0, 0, 0, 0, {6'd34, 6'd33, 6'd32});
        add_row(1, "intra_dep", slot(1, 10, 1, 11), slot(1, 12, 10, 10), slot(1, 10, 12, 4),
                0, 0, 0, 0, 0, {6'd37, 6'd36, 6'd35});
        add_row(2, "x0_invalid", slot(1, 0, 0, 3), slot(0, 5, 5, 5), slot(1, 13, 0, 0),
                0, 0, 0, 0, 0, {6'd38, 6'd0, 6'd0});
        add_row(3, "cdb_bypass", slot(1, 14, 1, 4), slot(1, 15, 2, 3), slot(1, 0, 0, 0),
                3'b011, {6'd0, 6'd33, 6'd32}, 0, 0, 0, {6'd0, 6'd40, 6'd39});
        add_row(4, "cdb_later", slot(1, 16, 1, 4), slot(0, 0, 0, 0), slot(0, 0, 0, 0),
                0, 0, 0, 0, 0, {6'd0, 6'd0, 6'd41});
        for (int r = 0; r < 7; r++) begin   // use up the initial pool
            add_row(5 + r, "fill", slot(1, 17 + 3 * r, r, 10), slot(1, 18 + 3 * r, 13, r + 1),
                    slot(1, (r < 5) ? 19 + 3 * r : 3 + 5 * (r - 5), 14, 16), 0, 0, 0, 0, 0,
                    {phys_reg_t'(44 + 3 * r), phys_reg_t'(43 + 3 * r), phys_reg_t'(42 + 3 * r)});
        end
        table_r[10].req[0].dest_ar = 5'd1;   // last two fill rows reuse low regs
        table_r[10].req[1].dest_ar = 5'd2;
        table_r[11].req[0].dest_ar = 5'd5;
        table_r[11].req[1].dest_ar = 5'd6;
        table_r[11].req[2].dest_ar = 5'd8;
        add_row(12, "stall_retire", slot(1, 9, 1, 2), slot(1, 11, 3, 4), slot(1, 12, 5, 6),
                0, 0, 3'b111, {6'd7, 6'd4, 6'd1}, 1, {6'd4, 6'd1, 6'd63});
        add_row(13, "reuse_order", slot(1, 13, 0, 0), slot(0, 0, 0, 0), slot(0, 0, 0, 0),
                0, 0, 0, 0, 0, {6'd0, 6'd0, 6'd7});
        add_row(14, "retire_wake", slot(1, 20, 13, 9), slot(0, 0, 0, 0), slot(0, 0, 0, 0),
                0, 0, 3'b111, {6'd8, 6'd6, 6'd5}, 0, {6'd0, 6'd0, 6'd5});
    endtask

    // wait until every accepted group has left the output
    task automatic wait_drain();
        int n;
        n = 0;
        while (pending != 0 && n < TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("timed out waiting for %0d groups to leave the output", pending);
        end
    endtask

    task automatic apply_row(input row_t row);
        int   cycles;
        logic taken;
        cycles   = 0;
        taken    = 1'b0;
        if (row.cv != '0) begin
            wait_drain();                       // empty output lets the group meet the broadcast
        end
        cur_name = row.name;
        cur_dest = row.dest;
        in_valid = 1'b1;
        in_req   = row.req;
        cdb_valid = row.cv;
        cdb_tag  = row.ct;
        if (!row.stall) begin
            retire_valid = row.rv;
            retire_told  = row.rt;
        end
        while (!taken && cycles < TIMEOUT) begin
            @(negedge clock);
            if (in_ready) begin
                taken = 1'b1;
                if (row.stall && cycles <= STALL) begin
                    tb_errors++;
                    $display("in_ready rose before retirement in %0s", row.name);
                end
            end
            @(posedge clock);
            #1;
            retire_valid = '0;                      // one cycle of returns only
            if (!taken && row.stall && cycles == STALL - 1) begin
                retire_valid = row.rv;
                retire_told  = row.rt;
            end
            cycles++;
        end
        in_valid  = 1'b0;
        cdb_valid = '0;
        if (!taken) begin
            tb_errors++;
            $display("timed out waiting for in_ready in %0s", row.name);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // random back-pressure
    initial begin
        seed      = 27411;
        out_ready = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            out_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        retire_valid = '0;
        retire_told = '0;
        cur_name = "reset";
        cur_dest = '0;
        tb_errors = 0;
        build_table();
        repeat (10) @(posedge clock);
        #1;
        arst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) apply_row(table_r[r]);
        wait_drain();                               // let the last group drain
        repeat (2) @(posedge clock);
        $display("errors: testbench %0d, checker %0d", tb_errors, chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/rename_pkg.sv
logic/rename_ifs.sv
logic/map_table.sv
logic/free_list.sv
logic/rename_combiner.sv
logic/rename_unit.sv
test/rename_checker.sv
test/tb_rename.sv
